// ==== run.sh ====
#!/bin/sh
# Build and run the idExCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f verilog.f --top-module idExCoreTb -o simv \
	> build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== source/aluExecute.sv ====
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module aluExecute (
	input pipelinePkg::idExBundle exBundle,
	output pipelinePkg::exOutBundle exOut
);
	import pipelinePkg::*;

	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	logic [4:0] shamt;
	logic [`DATA_WIDTH-1:0] aluOut;
	logic [`DATA_WIDTH-1:0] linkAddr;
	logic [3:0] laneMask;
	logic [`DATA_WIDTH-1:0] laneData;

	// Operand selection
	always_comb begin
		case (exBundle.srcA)
			srcAPc: opA = exBundle.pc;
			srcAZero: opA = '0;
			default: opA = exBundle.rd1;
		endcase
	end

	assign opB = (exBundle.srcB == srcBImm) ? exBundle.imm : exBundle.rd2;
	assign shamt = opB[4:0];

	always_comb begin
		case (exBundle.aluOp)
			aluAdd: aluOut = opA + opB;
			aluSub: aluOut = opA - opB;
			aluSll: aluOut = opA << shamt;
			aluSlt: aluOut = `DATA_WIDTH'($signed(opA) < $signed(opB));
			aluSltu: aluOut = `DATA_WIDTH'(opA < opB);
			aluXor: aluOut = opA ^ opB;
			aluSrl: aluOut = opA >> shamt;
			aluSra: aluOut = `DATA_WIDTH'($signed(opA) >>> shamt);
			aluOr: aluOut = opA | opB;
			aluAnd: aluOut = opA & opB;
			default: aluOut = opB;
		endcase
	end

	assign linkAddr = exBundle.pc + `DATA_WIDTH'(4);

	// Byte lanes by access size and low address bits
	always_comb begin
		case (exBundle.memSize)
			`MEM_SIZE_BYTE: begin
				laneMask = 4'b0001 << aluOut[1:0];
				laneData = {4{exBundle.rd2[7:0]}};
			end
			`MEM_SIZE_HALF: begin
				laneMask = 4'b0011 << {aluOut[1], 1'b0};
				laneData = {2{exBundle.rd2[15:0]}};
			end
			default: begin
				laneMask = 4'b1111;
				laneData = exBundle.rd2;
			end
		endcase
	end

	always_comb begin
		exOut.pc = exBundle.pc;
		exOut.result = exBundle.isJump ? linkAddr : aluOut;
		exOut.writeAddr = exBundle.writeAddr;
		exOut.rfWe = exBundle.rfWe;
		exOut.isJump = exBundle.isJump;
		// JALR target drops bit 0
		if (exBundle.isJumpReg) begin
			exOut.jumpTarget = {aluOut[`DATA_WIDTH-1:1], 1'b0};
		end else begin
			exOut.jumpTarget = aluOut;
		end
		exOut.isLoad = exBundle.isLoad;
		exOut.memRead = exBundle.memRead;
		exOut.memWen = exBundle.memWen;
		if (exBundle.memRead || exBundle.memWen) begin
			exOut.byteEnable = laneMask;
		end else begin
			exOut.byteEnable = 4'b0000;
		end
		exOut.storeData = laneData;
	end

endmodule

// ==== source/idExCore.sv ====
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module idExCore (
	input logic CLK,
	input logic RSTn,
	input logic instValid,
	input logic [`DATA_WIDTH-1:0] inst,
	input logic [`DATA_WIDTH-1:0] pc,
	output logic outValid,
	output pipelinePkg::exOutBundle outBundle
);
	import pipelinePkg::*;

	logic decValid;
	idExBundle decBundle;
	logic exValid;
	idExBundle exBundle;
	exOutBundle exResult;

	// Decode with register file, written back from the EX/WB register
	instDecode decode (
		.CLK(CLK),
		.RSTn(RSTn),
		.instValid(instValid),
		.inst(inst),
		.pc(pc),
		.wbValid(outValid),
		.wbBundle(outBundle),
		.decValid(decValid),
		.decBundle(decBundle)
	);

	pipeReg #(
		.payloadType(idExBundle)
	) idExReg (
		.CLK(CLK),
		.RSTn(RSTn),
		.inValid(decValid),
		.inData(decBundle),
		.outValid(exValid),
		.outData(exBundle)
	);

	aluExecute execute (
		.exBundle(exBundle),
		.exOut(exResult)
	);

	pipeReg #(
		.payloadType(exOutBundle)
	) exWbReg (
		.CLK(CLK),
		.RSTn(RSTn),
		.inValid(exValid),
		.inData(exResult),
		.outValid(outValid),
		.outData(outBundle)
	);

endmodule

// ==== source/instDecode.sv ====
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module instDecode (
	input logic CLK,
	input logic RSTn,
	input logic instValid,
	input logic [`DATA_WIDTH-1:0] inst,
	input logic [`DATA_WIDTH-1:0] pc,
	input logic wbValid,
	input pipelinePkg::exOutBundle wbBundle,
	output logic decValid,
	output pipelinePkg::idExBundle decBundle
);
	import pipelinePkg::*;

	logic [`DATA_WIDTH-1:0] regFile [`REG_COUNT];

	logic [6:0] opcode;
	logic [`REG_ADDR_WIDTH-1:0] rd;
	logic [`REG_ADDR_WIDTH-1:0] rs1;
	logic [`REG_ADDR_WIDTH-1:0] rs2;
	logic [2:0] funct3;
	logic [6:0] funct7;

	logic [`DATA_WIDTH-1:0] immI;
	logic [`DATA_WIDTH-1:0] immS;
	logic [`DATA_WIDTH-1:0] immU;
	logic [`DATA_WIDTH-1:0] immJ;

	aluOpType functOp;

	assign opcode = inst[6:0];
	assign rd = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign funct7 = inst[31:25];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// ALU operation from funct3, funct7[5] picks sub and sra
	always_comb begin
		case (funct3)
			3'b000: functOp = (opcode == `OPCODE_OP && funct7[5]) ? aluSub : aluAdd;
			3'b001: functOp = aluSll;
			3'b010: functOp = aluSlt;
			3'b011: functOp = aluSltu;
			3'b100: functOp = aluXor;
			3'b101: functOp = funct7[5] ? aluSra : aluSrl;
			3'b110: functOp = aluOr;
			default: functOp = aluAnd;
		endcase
	end

	always_comb begin
		decBundle = '0;
		decBundle.pc = pc;
		decBundle.rd1 = regFile[rs1];
		decBundle.rd2 = regFile[rs2];
		decBundle.writeAddr = rd;
		decBundle.aluOp = aluAdd;
		decBundle.srcA = srcAReg;
		decBundle.srcB = srcBReg;
		case (opcode)
			`OPCODE_OP: begin
				decBundle.aluOp = functOp;
				decBundle.rfWe = 1'b1;
			end
			`OPCODE_OPIMM: begin
				decBundle.aluOp = functOp;
				decBundle.srcB = srcBImm;
				decBundle.imm = immI;
				decBundle.rfWe = 1'b1;
			end
			`OPCODE_LUI: begin
				decBundle.aluOp = aluPassB;
				decBundle.srcA = srcAZero;
				decBundle.srcB = srcBImm;
				decBundle.imm = immU;
				decBundle.rfWe = 1'b1;
			end
			`OPCODE_AUIPC: begin
				decBundle.srcA = srcAPc;
				decBundle.srcB = srcBImm;
				decBundle.imm = immU;
				decBundle.rfWe = 1'b1;
			end
			`OPCODE_JAL: begin
				decBundle.srcA = srcAPc;
				decBundle.srcB = srcBImm;
				decBundle.imm = immJ;
				decBundle.isJump = 1'b1;
				decBundle.rfWe = 1'b1;
			end
			`OPCODE_JALR: begin
				decBundle.srcB = srcBImm;
				decBundle.imm = immI;
				decBundle.isJump = 1'b1;
				decBundle.isJumpReg = 1'b1;
				decBundle.rfWe = 1'b1;
			end
			`OPCODE_LOAD: begin
				decBundle.srcB = srcBImm;
				decBundle.imm = immI;
				decBundle.isLoad = 1'b1;
				decBundle.memRead = 1'b1;
				decBundle.memSize = funct3[1:0];
				decBundle.memUnsigned = funct3[2];
				decBundle.rfWe = 1'b1;
			end
			`OPCODE_STORE: begin
				decBundle.srcB = srcBImm;
				decBundle.imm = immS;
				decBundle.memWen = 1'b1;
				decBundle.memSize = funct3[1:0];
			end
			default: begin
				// Unknown opcode passes through with no side effects
				decBundle.rfWe = 1'b0;
			end
		endcase
		// x0 is never a write target
		if (rd == '0) begin
			decBundle.rfWe = 1'b0;
		end
	end

	assign decValid = instValid;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbValid && wbBundle.rfWe) begin
			regFile[wbBundle.writeAddr] <= wbBundle.result;
		end
	end

endmodule

// ==== source/pipeReg.sv ====
`timescale 1ns/100ps

module pipeReg #(
	parameter type payloadType = logic
) (
	input logic CLK,
	input logic RSTn,
	input logic inValid,
	input payloadType inData,
	output logic outValid,
	output payloadType outData
);

	// Only the valid bit is cleared, the payload follows its input
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			outValid <= 1'b0;
		end else begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge CLK) begin
		outData <= inData;
	end

endmodule

// ==== source/pipelinePkg.sv ====
`include "pipeline_defines.svh"

package pipelinePkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB
	} aluOpType;

	typedef enum logic [1:0] {
		srcAReg,
		srcAPc,
		srcAZero
	} srcASel;

	typedef enum logic {
		srcBReg,
		srcBImm
	} srcBSel;

	// Decoded instruction, captured by the ID/EX register
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] pc;
		logic [`DATA_WIDTH-1:0] imm;
		logic [`DATA_WIDTH-1:0] rd1;
		logic [`DATA_WIDTH-1:0] rd2;
		logic [`REG_ADDR_WIDTH-1:0] writeAddr;
		aluOpType aluOp;
		srcASel srcA;
		srcBSel srcB;
		logic isJump;
		logic isJumpReg;
		logic isLoad;
		logic memWen;
		logic memRead;
		logic [1:0] memSize;
		logic memUnsigned;
		logic rfWe;
	} idExBundle;

	// Execute result, captured by the EX/WB register
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] pc;
		logic [`DATA_WIDTH-1:0] result;
		logic [`REG_ADDR_WIDTH-1:0] writeAddr;
		logic rfWe;
		logic isJump;
		logic [`DATA_WIDTH-1:0] jumpTarget;
		logic isLoad;
		logic memRead;
		logic memWen;
		logic [3:0] byteEnable;
		logic [`DATA_WIDTH-1:0] storeData;
	} exOutBundle;

endpackage

// ==== source/pipeline_defines.svh ====
`ifndef PIPELINE_DEFINES_SVH
`define PIPELINE_DEFINES_SVH

// Machine word and register file geometry
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// RV32I major opcodes
`define OPCODE_OP 7'b0110011
`define OPCODE_OPIMM 7'b0010011
`define OPCODE_LUI 7'b0110111
`define OPCODE_AUIPC 7'b0010111
`define OPCODE_JAL 7'b1101111
`define OPCODE_JALR 7'b1100111
`define OPCODE_LOAD 7'b0000011
`define OPCODE_STORE 7'b0100011

// Memory access sizes as carried in funct3[1:0]
`define MEM_SIZE_BYTE 2'b00
`define MEM_SIZE_HALF 2'b01
`define MEM_SIZE_WORD 2'b10

`endif

// ==== verification/idExCoreTb.sv ====
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module idExCoreTb;
	import pipelinePkg::*;

	localparam int NUM_INST = 300;
	localparam int TIMEOUT_CYCLES = NUM_INST * 3 + 100;

	logic CLK;
	logic RSTn;
	logic instValid;
	logic [`DATA_WIDTH-1:0] inst;
	logic [`DATA_WIDTH-1:0] pc;
	logic outValid;
	exOutBundle outBundle;

	logic [`REG_COUNT-1:0][`DATA_WIDTH-1:0] modelRf;
	exOutBundle expQ [$];
	// Destinations of the last two issue slots, bubbles count as x0
	logic [`REG_ADDR_WIDTH-1:0] recent [2];
	logic [1:0] validHist;
	int checkedCount;
	int cycleCount;

	idExCore i_dut (
		.CLK(CLK),
		.RSTn(RSTn),
		.instValid(instValid),
		.inst(inst),
		.pc(pc),
		.outValid(outValid),
		.outBundle(outBundle)
	);

	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	task automatic stopOnError();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on first error");
	endtask

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: outputs stopped arriving, %0d of %0d instructions seen",
				checkedCount, NUM_INST);
			stopOnError();
		end
	end

	// RV32I integer operation by funct3, alt selects sub or sra
	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << sh;
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: return alt ? 32'($signed(a) >>> sh) : a >> sh;
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [3:0] laneEnable(input logic [1:0] size, input logic [1:0] addrLow);
		case (size)
			2'b00: return 4'b0001 << addrLow;
			2'b01: return addrLow[1] ? 4'b1100 : 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic exOutBundle refExecute(input logic [31:0] ins, input logic [31:0] pcIn,
		input logic [`REG_COUNT-1:0][`DATA_WIDTH-1:0] rf);
		logic [6:0] opcode;
		logic [4:0] rd;
		logic [2:0] f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immU;
		logic [31:0] immJ;
		exOutBundle e;
		opcode = ins[6:0];
		rd = ins[11:7];
		f3 = ins[14:12];
		a = rf[ins[19:15]];
		b = rf[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immU = {ins[31:12], 12'b0};
		immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		e = '0;
		e.pc = pcIn;
		e.writeAddr = rd;
		case (opcode)
			`OPCODE_OP: begin
				e.result = aluRef(f3, ins[30], a, b);
				e.rfWe = 1'b1;
			end
			`OPCODE_OPIMM: begin
				e.result = aluRef(f3, f3 == 3'b101 && ins[30], a, immI);
				e.rfWe = 1'b1;
			end
			`OPCODE_LUI: begin
				e.result = immU;
				e.rfWe = 1'b1;
			end
			`OPCODE_AUIPC: begin
				e.result = pcIn + immU;
				e.rfWe = 1'b1;
			end
			`OPCODE_JAL: begin
				e.result = pcIn + 32'd4;
				e.isJump = 1'b1;
				e.jumpTarget = pcIn + immJ;
				e.rfWe = 1'b1;
			end
			`OPCODE_JALR: begin
				e.result = pcIn + 32'd4;
				e.isJump = 1'b1;
				e.jumpTarget = (a + immI) & ~32'd1;
				e.rfWe = 1'b1;
			end
			`OPCODE_LOAD: begin
				e.result = a + immI;
				e.isLoad = 1'b1;
				e.memRead = 1'b1;
				e.byteEnable = laneEnable(f3[1:0], e.result[1:0]);
				e.rfWe = 1'b1;
			end
			`OPCODE_STORE: begin
				e.result = a + immS;
				e.memWen = 1'b1;
				e.byteEnable = laneEnable(f3[1:0], e.result[1:0]);
				case (f3[1:0])
					2'b00: e.storeData = {4{b[7:0]}};
					2'b01: e.storeData = {2{b[15:0]}};
					default: e.storeData = b;
				endcase
			end
			default: e.result = '0;
		endcase
		e.rfWe = e.rfWe && (rd != 5'd0);
		return e;
	endfunction

	// Source register outside the last two destinations
	function automatic logic [4:0] pickSrc();
		logic [4:0] r;
		r = 5'($urandom);
		while (r != 5'd0 && (r == recent[0] || r == recent[1])) begin
			r = 5'($urandom);
		end
		return r;
	endfunction

	function automatic logic [31:0] genInst();
		int kind;
		int sel;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] shamt;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm12;
		kind = int'($urandom % 9);
		rd = 5'($urandom);
		rs1 = pickSrc();
		rs2 = pickSrc();
		f3 = 3'($urandom);
		imm12 = 12'($urandom);
		shamt = ($urandom % 4 == 0) ? 5'd31 : 5'($urandom);
		f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
		case (kind)
			0, 1: return {f7, rs2, rs1, f3, rd, `OPCODE_OP};
			2, 3: begin
				if (f3 == 3'b001) imm12 = {7'h00, shamt};
				if (f3 == 3'b101) imm12 = {f7, shamt};
				return {imm12, rs1, f3, rd, `OPCODE_OPIMM};
			end
			4: return {20'($urandom), rd, `OPCODE_LUI};
			5: return {20'($urandom), rd, `OPCODE_AUIPC};
			6: begin
				if ($urandom % 2 == 1) return {20'($urandom), rd, `OPCODE_JAL};
				return {imm12, rs1, 3'b000, rd, `OPCODE_JALR};
			end
			7: begin
				sel = int'($urandom % 5);
				f3 = (sel < 3) ? 3'(sel) : 3'(sel + 1);
				return {imm12, rs1, f3, rd, `OPCODE_LOAD};
			end
			default: begin
				f3 = 3'($urandom % 3);
				return {imm12[11:5], rs2, rs1, f3, imm12[4:0], `OPCODE_STORE};
			end
		endcase
	endfunction

	task automatic shiftRecent(input logic [4:0] wr);
		recent[1] = recent[0];
		recent[0] = wr;
	endtask

	task automatic checkValid(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected outValid %b, actual %b", name, exp, act);
			stopOnError();
		end
	endtask

	task automatic checkWriteback(string name, exOutBundle exp, exOutBundle act);
		string expText;
		string actText;
		if (act.result !== exp.result || act.rfWe !== exp.rfWe ||
			act.writeAddr !== exp.writeAddr || act.pc !== exp.pc) begin
			expText = $sformatf("pc %h result %h rfWe %b rd %0d",
				exp.pc, exp.result, exp.rfWe, exp.writeAddr);
			actText = $sformatf("pc %h result %h rfWe %b rd %0d",
				act.pc, act.result, act.rfWe, act.writeAddr);
			$display("[FAIL] %s writeback: expected %s, actual %s", name, expText, actText);
			stopOnError();
		end
	endtask

	task automatic checkMemAccess(string name, exOutBundle exp, exOutBundle act);
		string expText;
		string actText;
		if (act.isLoad !== exp.isLoad || act.memRead !== exp.memRead ||
			act.memWen !== exp.memWen || act.byteEnable !== exp.byteEnable ||
			(exp.memWen && act.storeData !== exp.storeData)) begin
			expText = $sformatf("ld %b rd %b wr %b be %b data %h",
				exp.isLoad, exp.memRead, exp.memWen, exp.byteEnable, exp.storeData);
			actText = $sformatf("ld %b rd %b wr %b be %b data %h",
				act.isLoad, act.memRead, act.memWen, act.byteEnable, act.storeData);
			$display("[FAIL] %s memory: expected %s, actual %s", name, expText, actText);
			stopOnError();
		end
	endtask

	task automatic checkJump(string name, exOutBundle exp, exOutBundle act);
		if (act.isJump !== exp.isJump || (exp.isJump && act.jumpTarget !== exp.jumpTarget)) begin
			$display("[FAIL] %s jump: expected isJump %b target %h, actual isJump %b target %h",
				name, exp.isJump, exp.jumpTarget, act.isJump, act.jumpTarget);
			stopOnError();
		end
	endtask

	// Compare outputs at the falling edge, away from register updates
	initial begin
		exOutBundle exp;
		string name;
		forever begin
			@(negedge CLK);
			if (!RSTn) begin
				checkValid("output timing", validHist[1], outValid);
				if (outValid) begin
					if (expQ.size() == 0) begin
						$display("Output appeared with no instruction pending");
						stopOnError();
					end
					exp = expQ.pop_front();
					name = $sformatf("inst %0d at pc %h", checkedCount, exp.pc);
					checkWriteback(name, exp, outBundle);
					checkMemAccess(name, exp, outBundle);
					checkJump(name, exp, outBundle);
					checkedCount++;
				end
			end
			validHist = {validHist[0], instValid};
		end
	end

	initial begin
		logic [31:0] newInst;
		logic [31:0] newPc;
		exOutBundle e;
		RSTn = 1'b1;
		instValid = 1'b0;
		inst = '0;
		pc = '0;
		modelRf = '0;
		recent[0] = '0;
		recent[1] = '0;
		validHist = '0;
		checkedCount = 0;
		cycleCount = 0;
		repeat (8) @(posedge CLK);
		RSTn <= 1'b0;
		void'($urandom(32'h04fe_3a95));
		for (int i = 0; i < NUM_INST; i++) begin
			@(posedge CLK);
			if ($urandom % 5 == 0) begin
				instValid <= 1'b0;
				shiftRecent(5'd0);
				@(posedge CLK);
			end
			newInst = genInst();
			newPc = {30'($urandom), 2'b00};
			instValid <= 1'b1;
			inst <= newInst;
			pc <= newPc;
			e = refExecute(newInst, newPc, modelRf);
			expQ.push_back(e);
			if (e.rfWe) modelRf[e.writeAddr] = e.result;
			shiftRecent(newInst[6:0] == `OPCODE_STORE ? 5'd0 : newInst[11:7]);
		end
		@(posedge CLK);
		instValid <= 1'b0;
		wait (checkedCount == NUM_INST);
		repeat (3) @(negedge CLK);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== verification/idExCore_assertions.sv ====
`timescale 1ns/100ps

module idExCore_assertions (
	input logic CLK,
	input logic RSTn,
	input logic instValid,
	input logic outValid,
	input pipelinePkg::exOutBundle outBundle
);
	import pipelinePkg::*;

	// instValid of one cycle shows on outValid two cycles later
	property validLatency;
		@(posedge CLK) (!$past(RSTn, 1) && !$past(RSTn, 2))
			|-> (outValid == $past(instValid, 2));
	endproperty

	property validLowAfterReset;
		@(posedge CLK) $past(RSTn) |-> !outValid;
	endproperty

	property noStoreWriteback;
		@(posedge CLK) disable iff (RSTn)
			outValid |-> !(outBundle.memWen && outBundle.rfWe);
	endproperty

	property enableMatchesAccess;
		@(posedge CLK) disable iff (RSTn)
			outValid |-> ((outBundle.byteEnable != 4'b0) == (outBundle.memRead || outBundle.memWen));
	endproperty

	assert property (validLatency) else $error("outValid does not follow instValid");
	assert property (validLowAfterReset) else $error("outValid high after reset");
	assert property (noStoreWriteback) else $error("memWen and rfWe both high");
	assert property (enableMatchesAccess) else $error("byteEnable disagrees with access");

endmodule

bind idExCore idExCore_assertions outputChecks (
	.CLK(CLK),
	.RSTn(RSTn),
	.instValid(instValid),
	.outValid(outValid),
	.outBundle(outBundle)
);

// ==== verilog.f ====
+incdir+source
source/pipelinePkg.sv
source/instDecode.sv
source/pipeReg.sv
source/aluExecute.sv
source/idExCore.sv
verification/idExCore_assertions.sv
verification/idExCoreTb.sv
